// File: hw/neighbor_pkg.sv
package neighbor_pkg;

    // default sizing, top level may override counts
    localparam int NUM_PE     = 4;
    localparam int NUM_BANKS  = 4;
    localparam int BANK_DEPTH = 64;
    localparam int ID_W       = 16;
    localparam int MAX_DEG    = 16;

    localparam int ROW_W  = $clog2(BANK_DEPTH);
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int PE_W   = $clog2(NUM_PE);
    localparam int DEG_W  = $clog2(MAX_DEG);   // holds degree minus one

    // upstream request, one entry in the request FIFO
    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;     // start row inside the bank
        logic [DEG_W-1:0]  deg_m1;
        logic [PE_W-1:0]   pe_tag;  // destination edge PE
    } neighbor_req_t;

    // dispatcher to one bank controller
    typedef struct packed {
        logic              valid;
        logic [ROW_W-1:0]  row;
        logic [DEG_W-1:0]  deg_m1;
        logic [PE_W-1:0]   pe_tag;
    } bank_cmd_t;

    // bank controller output, still tagged with its PE
    typedef struct packed {
        logic              valid;
        logic              sos;
        logic              eos;
        logic [DEG_W-1:0]  iter;
        logic [ID_W-1:0]   id;
        logic [PE_W-1:0]   pe_tag;
    } bank_stream_t;

    // per-PE output port
    typedef struct packed {
        logic              valid;
        logic              sos;
        logic              eos;
        logic [DEG_W-1:0]  iter;
        logic [ID_W-1:0]   id;
    } pe_stream_t;

endpackage

// File: hw/neighbor_req_fifo.sv
`timescale 1ns/100ps

module neighbor_req_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  neighbor_pkg::neighbor_req_t wdata,
    input  logic                        pop,
    output neighbor_pkg::neighbor_req_t rdata,
    output logic                        wfull,
    output logic                        rempty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    neighbor_pkg::neighbor_req_t mem [FIFO_DEPTH];

    // extra msb is the wrap bit
    logic [AW:0] wptr;
    logic [AW:0] rptr;
    logic        do_push;
    logic        do_pop;

    assign do_push = push && !wfull;    // requests while full are dropped
    assign do_pop  = pop && !rempty;

    assign rempty = (wptr == rptr);
    assign wfull  = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

    // show-ahead head
    assign rdata = mem[rptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wptr[AW-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (do_push) begin
                wptr <= wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

endmodule

// File: hw/neighbor_dispatch.sv
`timescale 1ns/100ps

module neighbor_dispatch #(
    parameter int NUM_PE    = neighbor_pkg::NUM_PE,
    parameter int NUM_BANKS = neighbor_pkg::NUM_BANKS
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  neighbor_pkg::neighbor_req_t                head,
    input  logic                                       empty,
    input  logic [NUM_BANKS-1:0]                       bank_busy,
    input  neighbor_pkg::bank_stream_t [NUM_BANKS-1:0] bank_stream,
    output logic                                       pop,
    output neighbor_pkg::bank_cmd_t [NUM_BANKS-1:0]    cmd
);

    // one bit per PE, stream issued and eos not yet seen
    logic [NUM_PE-1:0] pending;
    logic [NUM_PE-1:0] pe_done;
    logic              bank_free;
    logic              pe_free;

    // a bank commanded last cycle has not raised busy yet
    assign bank_free = !bank_busy[head.bank] && !cmd[head.bank].valid;
    assign pe_free   = !pending[head.pe_tag];
    assign pop       = !empty && bank_free && pe_free;

    always_comb begin
        pe_done = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_stream[b].valid && bank_stream[b].eos) begin
                pe_done[bank_stream[b].pe_tag] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            for (int p = 0; p < NUM_PE; p++) begin
                if (pop && head.pe_tag == neighbor_pkg::PE_W'(p)) begin
                    pending[p] <= 1'b1;
                end else if (pe_done[p]) begin
                    pending[p] <= 1'b0;
                end
            end
        end
    end

    // one-cycle command strobe to the addressed bank
    always_ff @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            cmd[b].row    <= head.row;
            cmd[b].deg_m1 <= head.deg_m1;
            cmd[b].pe_tag <= head.pe_tag;
            if (rst) begin
                cmd[b].valid <= 1'b0;
            end else begin
                cmd[b].valid <= pop && (head.bank == neighbor_pkg::BANK_W'(b));
            end
        end
    end

endmodule

// File: hw/neighbor_bank_ctrl.sv
`timescale 1ns/100ps

module neighbor_bank_ctrl #(
    parameter int BANK_DEPTH = neighbor_pkg::BANK_DEPTH
) (
    input  logic                             clk,
    input  logic                             rst,
    input  neighbor_pkg::bank_cmd_t          cmd,
    input  logic [neighbor_pkg::ID_W-1:0]    rd_data,
    output logic                             rd_en,
    output logic [neighbor_pkg::ROW_W-1:0]   rd_row,
    output neighbor_pkg::bank_stream_t       stream,
    output logic                             busy
);

    localparam logic IDLE = 1'b0;
    localparam logic RUN  = 1'b1;

    logic                             state;
    logic [neighbor_pkg::ROW_W-1:0]   addr;
    logic [neighbor_pkg::DEG_W-1:0]   remain;   // reads left after this one
    logic [neighbor_pkg::DEG_W-1:0]   iter;
    logic [neighbor_pkg::PE_W-1:0]    pe_tag;
    logic                             last;

    // read stage, lines up with rd_data
    logic                             s_valid;
    logic                             s_sos;
    logic                             s_eos;
    logic [neighbor_pkg::DEG_W-1:0]   s_iter;
    logic [neighbor_pkg::PE_W-1:0]    s_pe;

    assign last   = (remain == '0);
    assign rd_en  = (state == RUN);
    assign rd_row = addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (state == IDLE && cmd.valid) begin
            state <= RUN;
        end else if (state == RUN && last) begin
            state <= IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin     // track cmd until it fires
            addr   <= cmd.row;
            remain <= cmd.deg_m1;
            iter   <= '0;
            pe_tag <= cmd.pe_tag;
        end else begin
            addr   <= (addr == neighbor_pkg::ROW_W'(BANK_DEPTH - 1)) ? '0 : addr + 1'b1;
            remain <= remain - 1'b1;
            iter   <= iter + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        s_iter <= iter;
        s_pe   <= pe_tag;
        if (rst) begin
            s_valid <= 1'b0;
            s_sos   <= 1'b0;
            s_eos   <= 1'b0;
        end else begin
            s_valid <= rd_en;
            s_sos   <= rd_en && (iter == '0);
            s_eos   <= rd_en && last;
        end
    end

    // held through the eos cycle
    assign busy = (state == RUN) || s_valid;

    always_comb begin
        stream.valid  = s_valid;
        stream.sos    = s_sos;
        stream.eos    = s_eos;
        stream.iter   = s_iter;
        stream.id     = rd_data;
        stream.pe_tag = s_pe;
    end

endmodule

// File: hw/neighbor_sram.sv
`timescale 1ns/100ps

module neighbor_sram #(
    parameter int BANK_DEPTH = neighbor_pkg::BANK_DEPTH
) (
    input  logic                             clk,
    input  logic                             we,
    input  logic [neighbor_pkg::ROW_W-1:0]   wrow,
    input  logic [neighbor_pkg::ID_W-1:0]    wdata,
    input  logic                             rd_en,
    input  logic [neighbor_pkg::ROW_W-1:0]   rd_row,
    output logic [neighbor_pkg::ID_W-1:0]    rd_data
);

    logic [neighbor_pkg::ID_W-1:0] mem [BANK_DEPTH];

    // load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrow] <= wdata;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_row];
        end
    end

endmodule

// File: hw/neighbor_bus.sv
`timescale 1ns/100ps

module neighbor_bus #(
    parameter int NUM_PE    = neighbor_pkg::NUM_PE,
    parameter int NUM_BANKS = neighbor_pkg::NUM_BANKS
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  neighbor_pkg::bank_stream_t [NUM_BANKS-1:0] bank_stream,
    output neighbor_pkg::pe_stream_t   [NUM_PE-1:0]    pe_out
);

    neighbor_pkg::pe_stream_t [NUM_PE-1:0] sel;

    // at most one bank targets a given PE at a time
    always_comb begin
        for (int p = 0; p < NUM_PE; p++) begin
            sel[p] = '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_stream[b].valid &&
                    bank_stream[b].pe_tag == neighbor_pkg::PE_W'(p)) begin
                    sel[p].valid = 1'b1;
                    sel[p].sos   = bank_stream[b].sos;
                    sel[p].eos   = bank_stream[b].eos;
                    sel[p].iter  = bank_stream[b].iter;
                    sel[p].id    = bank_stream[b].id;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PE; p++) begin
            pe_out[p] <= sel[p];
            if (rst) begin
                pe_out[p].valid <= 1'b0;   // strobes only
                pe_out[p].sos   <= 1'b0;
                pe_out[p].eos   <= 1'b0;
            end
        end
    end

endmodule

// File: hw/neighbor_fetch_top.sv
`timescale 1ns/100ps

module neighbor_fetch_top #(
    parameter int NUM_PE     = neighbor_pkg::NUM_PE,
    parameter int NUM_BANKS  = neighbor_pkg::NUM_BANKS,
    parameter int BANK_DEPTH = neighbor_pkg::BANK_DEPTH,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  req_valid,
    input  neighbor_pkg::neighbor_req_t           req,
    input  logic                                  load_valid,
    input  logic [neighbor_pkg::BANK_W-1:0]       load_bank,
    input  logic [neighbor_pkg::ROW_W-1:0]        load_row,
    input  logic [neighbor_pkg::ID_W-1:0]         load_id,
    output logic                                  wfull,
    output neighbor_pkg::pe_stream_t [NUM_PE-1:0] pe_out
);

    neighbor_pkg::neighbor_req_t                 fifo_head;
    logic                                        fifo_empty;
    logic                                        pop;
    neighbor_pkg::bank_cmd_t    [NUM_BANKS-1:0]  cmd;
    neighbor_pkg::bank_stream_t [NUM_BANKS-1:0]  bank_stream;
    logic [NUM_BANKS-1:0]                        bank_busy;
    logic [NUM_BANKS-1:0]                        rd_en;
    logic [NUM_BANKS-1:0][neighbor_pkg::ROW_W-1:0] rd_row;
    logic [NUM_BANKS-1:0][neighbor_pkg::ID_W-1:0]  rd_data;

    neighbor_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk    (clk),
        .rst    (rst),
        .push   (req_valid),
        .wdata  (req),
        .pop    (pop),
        .rdata  (fifo_head),
        .wfull  (wfull),
        .rempty (fifo_empty)
    );

    neighbor_dispatch #(
        .NUM_PE    (NUM_PE),
        .NUM_BANKS (NUM_BANKS)
    ) u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .head        (fifo_head),
        .empty       (fifo_empty),
        .bank_busy   (bank_busy),
        .bank_stream (bank_stream),
        .pop         (pop),
        .cmd         (cmd)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        neighbor_bank_ctrl #(
            .BANK_DEPTH (BANK_DEPTH)
        ) u_ctrl (
            .clk     (clk),
            .rst     (rst),
            .cmd     (cmd[i]),
            .rd_data (rd_data[i]),
            .rd_en   (rd_en[i]),
            .rd_row  (rd_row[i]),
            .stream  (bank_stream[i]),
            .busy    (bank_busy[i])
        );

        neighbor_sram #(
            .BANK_DEPTH (BANK_DEPTH)
        ) u_sram (
            .clk     (clk),
            .we      (load_valid && load_bank == neighbor_pkg::BANK_W'(i)),
            .wrow    (load_row),
            .wdata   (load_id),
            .rd_en   (rd_en[i]),
            .rd_row  (rd_row[i]),
            .rd_data (rd_data[i])
        );
    end

    neighbor_bus #(
        .NUM_PE    (NUM_PE),
        .NUM_BANKS (NUM_BANKS)
    ) u_bus (
        .clk         (clk),
        .rst         (rst),
        .bank_stream (bank_stream),
        .pe_out      (pe_out)
    );

endmodule

// File: tests/neighbor_fetch_tb.sv
`timescale 1ns/100ps

module neighbor_fetch_tb;

    localparam int NUM_PE      = neighbor_pkg::NUM_PE;
    localparam int NUM_BANKS   = neighbor_pkg::NUM_BANKS;
    localparam int BANK_DEPTH  = neighbor_pkg::BANK_DEPTH;
    localparam int FIFO_DEPTH  = 8;
    localparam int LONG_DEG_M1 = neighbor_pkg::MAX_DEG - 1;

    logic                                  clk;
    logic                                  rst;
    logic                                  req_valid;
    neighbor_pkg::neighbor_req_t           req;
    logic                                  load_valid;
    logic [neighbor_pkg::BANK_W-1:0]       load_bank;
    logic [neighbor_pkg::ROW_W-1:0]        load_row;
    logic [neighbor_pkg::ID_W-1:0]         load_id;
    logic                                  wfull;
    neighbor_pkg::pe_stream_t [NUM_PE-1:0] pe_out;

    logic [neighbor_pkg::ID_W-1:0] shadow [NUM_BANKS][BANK_DEPTH];
    neighbor_pkg::pe_stream_t      exp_q [NUM_PE][$];   // expected beats per PE
    neighbor_pkg::pe_stream_t      mon_exp;
    logic [31:0]                   lfsr;
    string                         test_name;

    neighbor_fetch_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .load_valid (load_valid),
        .load_bank  (load_bank),
        .load_row   (load_row),
        .load_id    (load_id),
        .wfull      (wfull),
        .pe_out     (pe_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_failed();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("Error in %s: %s", test_name, msg);
        stop_failed();
    endtask

    task automatic check_stream(input int pe, input neighbor_pkg::pe_stream_t exp,
                                input neighbor_pkg::pe_stream_t act);
        if (act !== exp) begin
            $display("Fail %s pe %0d: expected %h, actual %h", test_name, pe, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            $display("Fail %s: %s expected %b, actual %b", test_name, what, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (act != exp) begin
            $display("Fail %s: %s expected %0d, actual %0d", test_name, what, exp, act);
            stop_failed();
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic neighbor_pkg::neighbor_req_t rand_req(input int bank_bits,
                                                            input int deg_bits,
                                                            input int pe_bits);
        neighbor_pkg::neighbor_req_t r;
        r.bank   = neighbor_pkg::BANK_W'(rand_bits(bank_bits));
        r.row    = neighbor_pkg::ROW_W'(rand_bits(neighbor_pkg::ROW_W));
        r.deg_m1 = neighbor_pkg::DEG_W'(rand_bits(deg_bits));
        r.pe_tag = neighbor_pkg::PE_W'(rand_bits(pe_bits));
        return r;
    endfunction

    // reference list of consecutive rows wrapping at the bank end
    task automatic expect_list(input neighbor_pkg::neighbor_req_t r);
        neighbor_pkg::pe_stream_t e;
        int                       row;
        for (int i = 0; i <= int'(r.deg_m1); i++) begin
            row     = (int'(r.row) + i) % BANK_DEPTH;
            e.valid = 1'b1;
            e.sos   = (i == 0);
            e.eos   = (i == int'(r.deg_m1));
            e.iter  = neighbor_pkg::DEG_W'(i);
            e.id    = shadow[r.bank][row];
            exp_q[r.pe_tag].push_back(e);
        end
    endtask

    // one cycle of req_valid plus the expected list when keep is set
    task automatic offer_req(input neighbor_pkg::neighbor_req_t r, input bit keep);
        req_valid = 1'b1;
        req       = r;
        if (keep) begin
            expect_list(r);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic send_req(input neighbor_pkg::neighbor_req_t r);
        int waited;
        waited = 0;
        while (wfull) begin
            @(negedge clk);
            waited++;
            if (waited > 500) abort_run("request FIFO never left the full state");
        end
        offer_req(r, 1'b1);
    endtask

    function automatic bit all_drained();
        for (int p = 0; p < NUM_PE; p++) begin
            if (exp_q[p].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!all_drained()) begin
            @(negedge clk);
            n++;
            if (n > limit) abort_run("expected neighbor lists never finished arriving");
        end
    endtask

    task automatic load_banks();
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < BANK_DEPTH; r++) begin
                load_valid   = 1'b1;
                load_bank    = neighbor_pkg::BANK_W'(b);
                load_row     = neighbor_pkg::ROW_W'(r);
                load_id      = neighbor_pkg::ID_W'(rand_bits(neighbor_pkg::ID_W));
                shadow[b][r] = load_id;
                @(negedge clk);
            end
        end
        load_valid = 1'b0;
    endtask

    // every valid beat on a PE must be the next one expected there
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NUM_PE; p++) begin
                if (pe_out[p].valid) begin
                    if (exp_q[p].size() == 0) begin
                        abort_run($sformatf("unexpected neighbor ID on PE %0d", p));
                    end else begin
                        mon_exp = exp_q[p].pop_front();
                        check_stream(p, mon_exp, pe_out[p]);
                    end
                end
            end
        end
    end

    initial begin
        neighbor_pkg::neighbor_req_t r;
        int                          cycles;
        lfsr       = 32'hc41563f4;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        load_valid = 1'b0;
        load_bank  = '0;
        load_row   = '0;
        load_id    = '0;
        test_name  = "reset";
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(1'b0, wfull, "wfull after reset");

        test_name = "load_readback";
        load_banks();
        for (int n = 0; n < 32; n++) begin
            send_req(rand_req(neighbor_pkg::BANK_W, 0, neighbor_pkg::PE_W));
            wait_idle(50);
        end

        test_name = "stream_content";
        for (int n = 0; n < 24; n++) begin
            send_req(rand_req(neighbor_pkg::BANK_W, neighbor_pkg::DEG_W, neighbor_pkg::PE_W));
            wait_idle(100);
        end
        r        = rand_req(neighbor_pkg::BANK_W, 0, neighbor_pkg::PE_W);
        r.row    = neighbor_pkg::ROW_W'(BANK_DEPTH - 3);   // runs past the last row
        r.deg_m1 = neighbor_pkg::DEG_W'(7);
        send_req(r);
        wait_idle(100);

        test_name = "isolated_latency";
        for (int n = 0; n < 8; n++) begin
            r = rand_req(neighbor_pkg::BANK_W, neighbor_pkg::DEG_W, neighbor_pkg::PE_W);
            send_req(r);
            cycles = 1;
            while (!pe_out[r.pe_tag].sos) begin
                @(negedge clk);
                cycles++;
                if (cycles > 30) abort_run("no start of stream on the addressed PE");
            end
            check_count(5, cycles, "cycles from request to sos");
            wait_idle(100);
        end

        test_name = "ordering";
        for (int k = 0; k < 4; k++) begin
            for (int n = 0; n < 12; n++) begin
                send_req(rand_req(1, neighbor_pkg::DEG_W, 1));   // two banks and two PEs
            end
            wait_idle(2000);
        end
        for (int n = 0; n < 16; n++) begin
            send_req(rand_req(neighbor_pkg::BANK_W, neighbor_pkg::DEG_W, neighbor_pkg::PE_W));
        end
        wait_idle(2000);

        test_name = "fifo_full";
        for (int b = 0; b < NUM_BANKS; b++) begin
            r        = rand_req(0, 0, 0);
            r.bank   = neighbor_pkg::BANK_W'(b);
            r.deg_m1 = neighbor_pkg::DEG_W'(LONG_DEG_M1);
            r.pe_tag = neighbor_pkg::PE_W'(b);
            offer_req(r, 1'b1);
        end
        for (int n = 0; n < FIFO_DEPTH; n++) begin
            check_flag(1'b0, wfull, "wfull while the queue fills");
            r        = rand_req(0, 0, 0);
            r.deg_m1 = neighbor_pkg::DEG_W'(LONG_DEG_M1);
            offer_req(r, 1'b1);
        end
        check_flag(1'b1, wfull, "wfull with the queue full");
        r        = rand_req(0, 0, 0);
        r.bank   = neighbor_pkg::BANK_W'(1);
        r.pe_tag = neighbor_pkg::PE_W'(1);
        offer_req(r, 1'b0);   // dropped by the FIFO
        wait_idle(3000);
        check_flag(1'b0, wfull, "wfull after the queue drained");
        repeat (40) @(negedge clk);   // catch any stray beat

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: build.f
hw/neighbor_pkg.sv
hw/neighbor_req_fifo.sv
hw/neighbor_dispatch.sv
hw/neighbor_bank_ctrl.sv
hw/neighbor_sram.sv
hw/neighbor_bus.sv
hw/neighbor_fetch_top.sv
tests/neighbor_fetch_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary -f build.f --top-module neighbor_fetch_tb -o neighbor_sim \
    && ./obj_dir/neighbor_sim > sim.log 2>&1
grep -q "TESTS PASSED" sim.log 2>/dev/null \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }
